//--- verilog/pf_macros.svh
`ifndef PF_MACROS_SVH
`define PF_MACROS_SVH

// Packet buffer geometry
`define PF_PKT_BYTES 2048
`define PF_DATA_W    64
`define PF_WORD_AW   8     // 2048 bytes / 8 bytes per word
`define PF_BYTE_AW   11
`define PF_INC_W     4     // Byte increment 0..8 per beat

// Filter program storage
`define PF_CODE_DEPTH 512
`define PF_CODE_AW    9

`define PF_PLEN_W 32

`endif

//--- verilog/pf_pkg.sv
`include "pf_macros.svh"

package pf_pkg;

   // Same numbering as the BPF size field
   typedef enum logic [1:0] {
      SZ_WORD = 2'd0,
      SZ_HALF = 2'd1,
      SZ_BYTE = 2'd2
   } xfer_sz_e;

   typedef enum logic [2:0] {
      CLS_LD   = 3'd0,
      CLS_LDX  = 3'd1,
      CLS_ALU  = 3'd4,
      CLS_JMP  = 3'd5,
      CLS_RET  = 3'd6,
      CLS_MISC = 3'd7
   } bpf_class_e;

   typedef enum logic [2:0] {
      MODE_IMM = 3'd0,
      MODE_ABS = 3'd1,
      MODE_IND = 3'd2,      // k + X
      MODE_LEN = 3'd4
   } bpf_mode_e;

   // ALU operations in the low half, jump conditions in the high half
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_OR   = 4'd4,
      OP_AND  = 4'd5,
      OP_LSH  = 4'd6,
      OP_RSH  = 4'd7,
      OP_JA   = 4'd8,
      OP_JEQ  = 4'd9,
      OP_JGT  = 4'd10,
      OP_JGE  = 4'd11,
      OP_JSET = 4'd12
   } bpf_op_e;

   // Packet bytes are big-endian in a word: byte 0 sits in bits 63:56
   typedef struct packed {
      logic [`PF_WORD_AW-1:0] addr;
      logic [`PF_DATA_W-1:0]  data;
      logic [`PF_INC_W-1:0]   byte_inc;
   } snoop_beat_t;

   typedef struct packed {
      logic [`PF_CODE_AW-1:0] addr;
      logic [63:0]            instr;
   } code_wr_t;

   typedef struct packed {
      logic [`PF_BYTE_AW-1:0] addr;
      xfer_sz_e               size;
   } mem_rd_req_t;

   // src selects X over k; for MISC it picks txa, for RET it picks A
   typedef struct packed {
      bpf_op_e    op;
      logic       src;
      bpf_mode_e  mode;
      xfer_sz_e   size;
      logic [2:0] rsvd;
      bpf_class_e cls;
      logic [15:0] pad;     // Overlays jt and jf
      logic [31:0] k;
   } bpf_alu_view_t;

   typedef struct packed {
      logic [15:0] opcode;
      logic [7:0]  jt;
      logic [7:0]  jf;
      logic [31:0] k;
   } bpf_jmp_view_t;

   typedef union packed {
      bpf_alu_view_t as_alu;
      bpf_jmp_view_t as_jmp;
   } bpf_instr_u;

endpackage

//--- verilog/pkt_buffer.sv
`timescale 1ns/10ps
`include "pf_macros.svh"

module pkt_buffer
   import pf_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  snoop_beat_t            sn_beat,
   input  logic                   sn_wr_en,
   input  logic                   sn_done,
   input  logic                   rdy_for_sn_ack,
   input  mem_rd_req_t            cpu_rd,
   input  logic                   cpu_rd_en,
   input  logic                   cpu_acc,
   input  logic                   cpu_rej,
   input  logic                   rdy_for_cpu_ack,
   input  logic [`PF_WORD_AW-1:0] fwd_addr,
   input  logic                   fwd_rd_en,
   input  logic                   fwd_done,
   input  logic                   rdy_for_fwd_ack,
   output logic                   rdy_for_sn,
   output logic                   rdy_for_cpu,
   output logic [31:0]            resized_mem_data,
   output logic                   resized_mem_data_vld,
   output logic [`PF_PLEN_W-1:0]  cpu_byte_len,
   output logic [`PF_DATA_W-1:0]  fwd_rd_data,
   output logic                   fwd_rd_data_vld,
   output logic [`PF_PLEN_W-1:0]  fwd_byte_len,
   output logic                   rdy_for_fwd
);

   localparam int OFF_W = `PF_BYTE_AW - `PF_WORD_AW;
   localparam int BANK_AW = `PF_WORD_AW - 1;

   typedef enum logic [2:0] {
      ST_EMPTY,
      ST_SNOOP,
      ST_FILTER,
      ST_FWD_RDY,
      ST_FWD
   } buf_state_e;

   buf_state_e state;
   logic [`PF_PLEN_W-1:0] byte_len;
   logic sn_wr_ok;
   logic [`PF_WORD_AW-1:0] cpu_word;
   logic [BANK_AW-1:0] rd_idx [2];
   logic [`PF_DATA_W-1:0] rd_q [2];
   logic first_bank;
   logic [OFF_W-1:0] rd_off;
   xfer_sz_e rd_sz;
   logic [2*`PF_DATA_W-1:0] pair;
   logic [2*`PF_DATA_W-1:0] shifted;
   logic [31:0] win;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= ST_EMPTY;
         rdy_for_cpu <= 1'b0;
      end else begin
         case (state)
            ST_EMPTY: if (rdy_for_sn_ack) state <= ST_SNOOP;
            ST_SNOOP: begin
               if (sn_done) begin
                  state       <= ST_FILTER;
                  rdy_for_cpu <= 1'b1;
               end
            end
            ST_FILTER: begin
               if (rdy_for_cpu_ack) rdy_for_cpu <= 1'b0;
               if (cpu_acc) state <= ST_FWD_RDY;
               else if (cpu_rej) state <= ST_EMPTY;    // Dropped, buffer freed
            end
            ST_FWD_RDY: if (rdy_for_fwd_ack) state <= ST_FWD;
            ST_FWD: if (fwd_done) state <= ST_EMPTY;
            default: state <= ST_EMPTY;
         endcase
      end
   end

   assign rdy_for_sn  = (state == ST_EMPTY);
   assign rdy_for_fwd = (state == ST_FWD_RDY);
   assign sn_wr_ok    = sn_wr_en && (state == ST_SNOOP);

   // Length counts bytes, so a short last beat is exact
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         byte_len <= '0;
      end else if (rdy_for_sn && rdy_for_sn_ack) begin
         byte_len <= '0;
      end else if (sn_wr_ok) begin
         byte_len <= byte_len + {{(`PF_PLEN_W-`PF_INC_W){1'b0}}, sn_beat.byte_inc};
      end
   end

   assign cpu_byte_len = byte_len;
   assign fwd_byte_len = byte_len;

   // Even and odd word banks so a CPU read gets word w and w+1 together
   assign cpu_word = cpu_rd.addr[`PF_BYTE_AW-1:OFF_W];

   always_comb begin
      if (state == ST_FWD) begin
         rd_idx[0] = fwd_addr[`PF_WORD_AW-1:1];
         rd_idx[1] = fwd_addr[`PF_WORD_AW-1:1];
      end else begin
         rd_idx[0] = cpu_word[`PF_WORD_AW-1:1] + BANK_AW'(cpu_word[0]);
         rd_idx[1] = cpu_word[`PF_WORD_AW-1:1];
      end
   end

   for (genvar b = 0; b < 2; b++) begin : g_bank
      logic [`PF_DATA_W-1:0] mem [2**BANK_AW];

      always_ff @(posedge clk) begin
         if (sn_wr_ok && (sn_beat.addr[0] == 1'(b))) begin
            mem[sn_beat.addr[`PF_WORD_AW-1:1]] <= sn_beat.data;
         end
         rd_q[b] <= mem[rd_idx[b]];
      end
   end

   always_ff @(posedge clk) begin
      first_bank <= (state == ST_FWD) ? fwd_addr[0] : cpu_word[0];
      rd_off     <= cpu_rd.addr[OFF_W-1:0];
      rd_sz      <= cpu_rd.size;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resized_mem_data_vld <= 1'b0;
         fwd_rd_data_vld      <= 1'b0;
      end else begin
         resized_mem_data_vld <= cpu_rd_en && (state == ST_FILTER);
         fwd_rd_data_vld      <= fwd_rd_en && (state == ST_FWD);
      end
   end

   // First word on top, then shift the wanted byte up to the MSB
   assign pair    = first_bank ? {rd_q[1], rd_q[0]} : {rd_q[0], rd_q[1]};
   assign shifted = pair << {rd_off, 3'b000};
   assign win     = shifted[2*`PF_DATA_W-1 -: 32];

   always_comb begin
      case (rd_sz)
         SZ_BYTE: resized_mem_data = {24'd0, win[31:24]};
         SZ_HALF: resized_mem_data = {16'd0, win[31:16]};
         default: resized_mem_data = win;
      endcase
   end

   assign fwd_rd_data = pair[2*`PF_DATA_W-1 -: `PF_DATA_W];

endmodule

//--- verilog/inst_mem.sv
`timescale 1ns/10ps
`include "pf_macros.svh"

module inst_mem
   import pf_pkg::*;
(
   input  logic                   clk,
   input  code_wr_t               code_wr,
   input  logic                   inst_wr_en,
   input  logic [`PF_CODE_AW-1:0] inst_rd_addr,
   input  logic                   inst_rd_en,
   output logic [63:0]            inst_rd_data
);

   logic [63:0] mem [`PF_CODE_DEPTH];

   // Loader side
   always_ff @(posedge clk) begin
      if (inst_wr_en) begin
         mem[code_wr.addr] <= code_wr.instr;
      end
   end

   // Fetch side, data one cycle after the enable
   always_ff @(posedge clk) begin
      if (inst_rd_en) begin
         inst_rd_data <= mem[inst_rd_addr];
      end
   end

endmodule

//--- verilog/bpf_cpu.sv
`timescale 1ns/10ps
`include "pf_macros.svh"

module bpf_cpu
   import pf_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rdy_for_cpu,
   input  logic [31:0]            resized_mem_data,
   input  logic                   resized_mem_data_vld,
   input  logic [`PF_PLEN_W-1:0]  cpu_byte_len,
   input  logic [63:0]            inst_rd_data,
   output logic                   rdy_for_cpu_ack,
   output mem_rd_req_t            cpu_rd,
   output logic                   cpu_rd_en,
   output logic                   cpu_acc,
   output logic                   cpu_rej,
   output logic [`PF_CODE_AW-1:0] inst_rd_addr,
   output logic                   inst_rd_en
);

   typedef enum logic [1:0] {
      C_IDLE,
      C_FETCH,
      C_EXEC,
      C_LOAD
   } cpu_state_e;

   cpu_state_e state;
   logic [`PF_CODE_AW-1:0] pc;
   logic [31:0] a;
   logic [31:0] x;
   bpf_instr_u ir;
   logic [31:0] operand;
   logic [31:0] alu_res;
   logic taken;
   logic [31:0] jmp_off;
   logic [32:0] pc_next;
   logic pc_oob;
   logic [32:0] ld_addr;
   logic [2:0] nbytes;
   logic [33:0] ld_end;
   logic ld_oob;
   logic [31:0] ret_val;
   logic is_ret;
   logic is_load;
   logic cls_ok;
   logic exec_acc;
   logic exec_rej;

   assign ir = inst_rd_data;   // Held stable until the next fetch

   assign inst_rd_en   = (state == C_FETCH);
   assign inst_rd_addr = pc;

   assign operand = ir.as_alu.src ? x : ir.as_alu.k;

   always_comb begin
      case (ir.as_alu.op)
         OP_ADD:  alu_res = a + operand;
         OP_SUB:  alu_res = a - operand;
         OP_OR:   alu_res = a | operand;
         OP_AND:  alu_res = a & operand;
         OP_LSH:  alu_res = a << operand;
         OP_RSH:  alu_res = a >> operand;
         default: alu_res = a;
      endcase
   end

   // Conditional jumps compare against k only
   always_comb begin
      case (ir.as_alu.op)
         OP_JEQ:  taken = (a == ir.as_jmp.k);
         OP_JGT:  taken = (a > ir.as_jmp.k);
         OP_JGE:  taken = (a >= ir.as_jmp.k);
         OP_JSET: taken = |(a & ir.as_jmp.k);
         default: taken = 1'b0;
      endcase
      jmp_off = '0;
      if (ir.as_alu.cls == CLS_JMP) begin
         if (ir.as_alu.op == OP_JA) jmp_off = ir.as_jmp.k;
         else jmp_off = taken ? {24'd0, ir.as_jmp.jt} : {24'd0, ir.as_jmp.jf};
      end
   end

   // Wide sum so that running off the end of code is visible
   assign pc_next = 33'(pc) + 33'd1 + 33'(jmp_off);
   assign pc_oob  = (pc_next >= 33'(`PF_CODE_DEPTH));

   assign ld_addr = {1'b0, ir.as_alu.k} + ((ir.as_alu.mode == MODE_IND) ? {1'b0, x} : 33'd0);

   always_comb begin
      case (ir.as_alu.size)
         SZ_BYTE: nbytes = 3'd1;
         SZ_HALF: nbytes = 3'd2;
         default: nbytes = 3'd4;
      endcase
   end

   assign ld_end = {1'b0, ld_addr} + 34'(nbytes);
   assign ld_oob = (ld_end > 34'(cpu_byte_len));

   assign is_ret  = (ir.as_alu.cls == CLS_RET);
   assign is_load = (ir.as_alu.cls == CLS_LD) &&
                    (ir.as_alu.mode inside {MODE_ABS, MODE_IND});
   assign cls_ok  = ir.as_alu.cls inside {CLS_LD, CLS_LDX, CLS_ALU, CLS_JMP, CLS_RET, CLS_MISC};
   assign ret_val = ir.as_alu.src ? a : ir.as_alu.k;

   assign exec_acc = is_ret && (ret_val != '0);
   assign exec_rej = is_ret ? (ret_val == '0) : (!cls_ok || (is_load ? ld_oob : pc_oob));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state           <= C_IDLE;
         pc              <= '0;
         rdy_for_cpu_ack <= 1'b0;
         cpu_rd_en       <= 1'b0;
         cpu_acc         <= 1'b0;
         cpu_rej         <= 1'b0;
      end else begin
         rdy_for_cpu_ack <= 1'b0;
         cpu_rd_en       <= 1'b0;
         cpu_acc         <= 1'b0;
         cpu_rej         <= 1'b0;
         case (state)
            C_IDLE: begin
               if (rdy_for_cpu) begin
                  rdy_for_cpu_ack <= 1'b1;
                  pc              <= '0;
                  state           <= C_FETCH;
               end
            end
            C_FETCH: state <= C_EXEC;
            C_EXEC: begin
               if (exec_acc || exec_rej) begin
                  cpu_acc <= exec_acc;
                  cpu_rej <= exec_rej;
                  state   <= C_IDLE;
               end else if (is_load) begin
                  cpu_rd_en <= 1'b1;
                  state     <= C_LOAD;
               end else begin
                  pc    <= pc_next[`PF_CODE_AW-1:0];
                  state <= C_FETCH;
               end
            end
            C_LOAD: begin
               if (resized_mem_data_vld) begin
                  if (pc_oob) begin
                     cpu_rej <= 1'b1;
                     state   <= C_IDLE;
                  end else begin
                     pc    <= pc_next[`PF_CODE_AW-1:0];
                     state <= C_FETCH;
                  end
               end
            end
            default: state <= C_IDLE;
         endcase
      end
   end

   // Register file and read request
   always_ff @(posedge clk) begin
      if (state == C_IDLE) begin
         a <= '0;
         x <= '0;
      end else if (state == C_LOAD && resized_mem_data_vld) begin
         a <= resized_mem_data;
      end else if (state == C_EXEC) begin
         cpu_rd <= '{addr: ld_addr[`PF_BYTE_AW-1:0], size: ir.as_alu.size};
         case (ir.as_alu.cls)
            CLS_LD:   a <= (ir.as_alu.mode == MODE_LEN) ? cpu_byte_len : ir.as_alu.k;
            CLS_LDX:  x <= ir.as_alu.k;
            CLS_ALU:  a <= alu_res;
            CLS_MISC: begin
               if (ir.as_alu.src) a <= x;   // txa
               else x <= a;                 // tax
            end
            default: ;
         endcase
      end
   end

endmodule

//--- verilog/packetfilter_core.sv
`timescale 1ns/10ps
`include "pf_macros.svh"

module packetfilter_core
   import pf_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,

   // Snooper
   input  snoop_beat_t            sn_beat,
   input  logic                   sn_wr_en,
   input  logic                   sn_done,
   output logic                   rdy_for_sn,
   input  logic                   rdy_for_sn_ack,

   // Forwarder
   input  logic [`PF_WORD_AW-1:0] fwd_addr,
   input  logic                   fwd_rd_en,
   output logic [`PF_DATA_W-1:0]  fwd_rd_data,
   output logic                   fwd_rd_data_vld,
   output logic [`PF_PLEN_W-1:0]  fwd_byte_len,
   input  logic                   fwd_done,
   output logic                   rdy_for_fwd,
   input  logic                   rdy_for_fwd_ack,

   // Program loader, only while the CPU is idle
   input  code_wr_t               code_wr,
   input  logic                   inst_wr_en
);

   // Buffer to CPU
   mem_rd_req_t             cpu_rd;
   logic                    cpu_rd_en;
   logic [31:0]             resized_mem_data;
   logic                    resized_mem_data_vld;
   logic [`PF_PLEN_W-1:0]   cpu_byte_len;
   logic                    cpu_acc;
   logic                    cpu_rej;
   logic                    rdy_for_cpu;
   logic                    rdy_for_cpu_ack;

   // Instruction fetch
   logic [`PF_CODE_AW-1:0]  inst_rd_addr;
   logic                    inst_rd_en;
   logic [63:0]             inst_rd_data;

   pkt_buffer u_buf (.*);

   inst_mem u_imem (.*);

   bpf_cpu u_cpu (.*);

endmodule

//--- verification/pf_sva.sv
`timescale 1ns/10ps

module pf_sva (
   input logic clk,
   input logic rst_n,
   input logic cpu_acc,
   input logic cpu_rej,
   input logic rdy_for_sn,
   input logic rdy_for_fwd,
   input logic rdy_for_fwd_ack,
   input logic fwd_rd_en,
   input logic fwd_rd_data_vld,
   input logic fwd_done
);

   logic in_fwd;   // Follows the buffer's forward state from the handshakes
   int fail_cnt = 0;   // Failed assertions so far

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_fwd <= 1'b0;
      end else if (rdy_for_fwd && rdy_for_fwd_ack) begin
         in_fwd <= 1'b1;
      end else if (in_fwd && fwd_done) begin
         in_fwd <= 1'b0;
      end
   end

   a_one_verdict: assert property (@(posedge clk) disable iff (!rst_n)
      !(cpu_acc && cpu_rej))
      else begin
         $error("cpu_acc and cpu_rej high in the same cycle");
         fail_cnt++;
      end

   a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
      !(rdy_for_sn && rdy_for_fwd))
      else begin
         $error("rdy_for_sn and rdy_for_fwd high together");
         fail_cnt++;
      end

   // Read data strobe exactly one cycle after each accepted read
   a_fwd_vld: assert property (@(posedge clk) disable iff (!rst_n)
      (fwd_rd_en && in_fwd) |=> fwd_rd_data_vld)
      else begin
         $error("fwd_rd_data_vld missing after fwd_rd_en");
         fail_cnt++;
      end

   a_fwd_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
      fwd_rd_data_vld |-> $past(fwd_rd_en && in_fwd))
      else begin
         $error("fwd_rd_data_vld without an accepted fwd_rd_en");
         fail_cnt++;
      end

endmodule

bind packetfilter_core pf_sva u_sva (
   .clk             (clk),
   .rst_n           (rst_n),
   .cpu_acc         (cpu_acc),
   .cpu_rej         (cpu_rej),
   .rdy_for_sn      (rdy_for_sn),
   .rdy_for_fwd     (rdy_for_fwd),
   .rdy_for_fwd_ack (rdy_for_fwd_ack),
   .fwd_rd_en       (fwd_rd_en),
   .fwd_rd_data_vld (fwd_rd_data_vld),
   .fwd_done        (fwd_done)
);

//--- verification/pf_tb.sv
`timescale 1ns/10ps
`include "pf_macros.svh"

module pf_tb
   import pf_pkg::*;
();

   localparam int WAIT_LIMIT = 4000;   // Cycles allowed for any single wait
   localparam int MAX_WORDS  = 2**`PF_WORD_AW;

   logic                   clk;
   logic                   rst_n;
   snoop_beat_t            sn_beat;
   logic                   sn_wr_en;
   logic                   sn_done;
   logic                   rdy_for_sn;
   logic                   rdy_for_sn_ack;
   logic [`PF_WORD_AW-1:0] fwd_addr;
   logic                   fwd_rd_en;
   logic [`PF_DATA_W-1:0]  fwd_rd_data;
   logic                   fwd_rd_data_vld;
   logic [`PF_PLEN_W-1:0]  fwd_byte_len;
   logic                   fwd_done;
   logic                   rdy_for_fwd;
   logic                   rdy_for_fwd_ack;
   code_wr_t               code_wr;
   logic                   inst_wr_en;

   integer seed;
   integer fd;
   int checks_done;
   logic [8*24-1:0] test_name;
   logic [`PF_PLEN_W-1:0] pkt_len;
   int pkt_words;
   logic [`PF_DATA_W-1:0] pkt_data [MAX_WORDS];

   packetfilter_core u_dut (.*);

   always #5 clk = ~clk;

   // Inputs change and outputs are read 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic abort_test(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   // The bound checker counts its failed assertions
   always @(u_dut.u_sva.fail_cnt) begin
      if (u_dut.u_sva.fail_cnt != 0) abort_test("an assertion in pf_sva failed");
   end

   task automatic check_verdict(input logic exp_v, input logic act_v);
      checks_done++;
      if (exp_v !== act_v) begin
         abort_test($sformatf("[FAIL] %0s verdict expected %0s actual %0s", test_name,
                              exp_v ? "acc" : "rej", act_v ? "acc" : "rej"));
      end
   endtask

   task automatic check_len(input logic [`PF_PLEN_W-1:0] exp_l,
                            input logic [`PF_PLEN_W-1:0] act_l);
      checks_done++;
      if (exp_l !== act_l) begin
         abort_test($sformatf("[FAIL] %0s fwd_byte_len expected %0d actual %0d",
                              test_name, exp_l, act_l));
      end
   endtask

   task automatic check_word(input int idx, input logic [`PF_DATA_W-1:0] exp_w,
                             input logic [`PF_DATA_W-1:0] act_w);
      checks_done++;
      if (exp_w !== act_w) begin
         abort_test($sformatf("[FAIL] %0s word %0d expected %h actual %h",
                              test_name, idx, exp_w, act_w));
      end
   endtask

   task automatic wait_sn_ready();
      int n;
      n = 0;
      while (!rdy_for_sn) begin
         if (n == WAIT_LIMIT) abort_test("rdy_for_sn never rose");
         n++;
         next_cycle();
      end
   endtask

   // Accept shows as rdy_for_fwd and reject as the buffer coming back empty
   task automatic wait_verdict(output logic acc);
      int n;
      n = 0;
      while (!rdy_for_fwd && !rdy_for_sn) begin
         if (n == WAIT_LIMIT) abort_test("neither rdy_for_fwd nor rdy_for_sn rose after sn_done");
         n++;
         next_cycle();
      end
      acc = rdy_for_fwd;
   endtask

   task automatic load_program(input int count);
      int i;
      int rc;
      logic [63:0] w;
      wait_sn_ready();   // An empty buffer means an idle CPU
      for (i = 0; i < count; i++) begin
         rc = $fscanf(fd, "%h", w);
         if (rc != 1) abort_test("instruction word missing in tests file");
         code_wr.addr  = i[`PF_CODE_AW-1:0];
         code_wr.instr = w;
         inst_wr_en    = 1'b1;
         next_cycle();
         inst_wr_en    = 1'b0;
      end
   endtask

   task automatic read_packet();
      int i;
      int rc;
      rc = $fscanf(fd, "%d", pkt_len);
      if (rc != 1) abort_test("packet length missing in tests file");
      pkt_words = (pkt_len + 7) / 8;
      if (pkt_words > MAX_WORDS) abort_test("packet in tests file exceeds the buffer");
      for (i = 0; i < pkt_words; i++) begin
         rc = $fscanf(fd, "%h", pkt_data[i]);
         if (rc != 1) abort_test("packet word missing in tests file");
      end
   endtask

   task automatic snoop_packet();
      int i;
      int gap;
      logic [`PF_PLEN_W-1:0] left;
      wait_sn_ready();
      rdy_for_sn_ack = 1'b1;
      next_cycle();
      rdy_for_sn_ack = 1'b0;
      left = pkt_len;
      for (i = 0; i < pkt_words; i++) begin
         gap = $random(seed) & 3;
         repeat (gap) next_cycle();
         sn_beat.addr     = i[`PF_WORD_AW-1:0];
         sn_beat.data     = pkt_data[i];
         sn_beat.byte_inc = (left > 8) ? 4'd8 : left[`PF_INC_W-1:0];   // Short last beat
         left             = (left > 8) ? left - 8 : '0;
         sn_wr_en         = 1'b1;
         next_cycle();
         sn_wr_en         = 1'b0;
      end
      sn_done = 1'b1;
      next_cycle();
      sn_done = 1'b0;
   endtask

   task automatic forward_packet();
      int i;
      int n;
      int rc;
      logic [`PF_DATA_W-1:0] exp_w;
      rdy_for_fwd_ack = 1'b1;
      next_cycle();
      rdy_for_fwd_ack = 1'b0;
      for (i = 0; i < pkt_words; i++) begin
         rc = $fscanf(fd, "%h", exp_w);
         if (rc != 1) abort_test("forward word missing in tests file");
         fwd_addr  = i[`PF_WORD_AW-1:0];
         fwd_rd_en = 1'b1;
         next_cycle();
         fwd_rd_en = 1'b0;
         n = 0;
         while (!fwd_rd_data_vld) begin
            if (n == WAIT_LIMIT) abort_test("fwd_rd_data_vld never came");
            n++;
            next_cycle();
         end
         check_word(i, exp_w, fwd_rd_data);
      end
      fwd_done = 1'b1;
      next_cycle();
      fwd_done = 1'b0;
   endtask

   initial begin
      logic [8*16-1:0] tok;
      logic [8*160-1:0] line;
      logic act_acc;
      logic exp_acc;
      int rc;
      int count;
      bit at_end;
      clk             = 1'b0;
      rst_n           = 1'b0;
      sn_beat         = '0;
      sn_wr_en        = 1'b0;
      sn_done         = 1'b0;
      rdy_for_sn_ack  = 1'b0;
      fwd_addr        = '0;
      fwd_rd_en       = 1'b0;
      fwd_done        = 1'b0;
      rdy_for_fwd_ack = 1'b0;
      code_wr         = '0;
      inst_wr_en      = 1'b0;
      seed            = 32'h2c13;
      checks_done     = 0;
      test_name       = "none";
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;

      fd = $fopen("verification/pf_tests.txt", "r");
      if (fd == 0) abort_test("cannot open verification/pf_tests.txt");
      at_end = 1'b0;
      while (!at_end) begin
         rc = $fscanf(fd, "%s", tok);
         if (rc != 1) begin
            at_end = 1'b1;
         end else if (tok == "#") begin
            rc = $fgets(line, fd);   // Rest of a comment line
         end else if (tok == "prog") begin
            rc = $fscanf(fd, "%s %d", test_name, count);
            if (rc != 2) abort_test("program record incomplete in tests file");
            load_program(count);
         end else if (tok == "pkt") begin
            read_packet();
         end else if (tok == "exp") begin
            rc = $fscanf(fd, "%s", tok);
            if (rc != 1 || (tok != "acc" && tok != "rej")) begin
               abort_test("verdict record in tests file is neither acc nor rej");
            end
            exp_acc = (tok == "acc");
            snoop_packet();
            wait_verdict(act_acc);
            check_verdict(exp_acc, act_acc);
            if (act_acc) check_len(pkt_len, fwd_byte_len);
         end else if (tok == "fwd") begin
            forward_packet();
         end else begin
            abort_test($sformatf("unknown record %0s in tests file", tok));
         end
      end
      $fclose(fd);

      if (checks_done > 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         abort_test("tests file held no checks");
      end
   end

endmodule

//--- verification/pf_tests.txt
# prog <name> <count> <instr hex...> | pkt <bytes> <word hex...>
# exp <acc|rej> | fwd <expected forwarded word hex...>
prog ethertype_ipv4 4 014000000000000C 9005000100000800 000600000000FFFF 0006000000000000
pkt 24 FFFFFFFFFFFF0011 2233445508004500 001C000140000000
exp acc
fwd FFFFFFFFFFFF0011 2233445508004500 001C000140000000
prog ethertype_arp 4 014000000000000C 9005000100000800 000600000000FFFF 0006000000000000
pkt 24 FFFFFFFFFFFF0011 2233445508060001 0800060400010000
exp rej
prog short_len 4 0400000000000000 900500010000000D 0006000000000001 0006000000000000
pkt 13 0102030405060708 090A0B0C0D000000
exp acc
fwd 0102030405060708 090A0B0C0D000000
prog oob_word 2 010000000000000A 0006000000000001
pkt 12 0011223344556677 8899AABB00000000
exp rej
prog ind_half 8 0001000000000003 0240000000000004 5004000000000FF0 7004000000000004 0804000000000000 C005000100000008 0006000000000001 0006000000000000
pkt 16 0011223344556677 8899AABBCCDDEEFF
exp acc
fwd 0011223344556677 8899AABBCCDDEEFF
prog reload_arp 4 014000000000000C 9005000100000806 0806000000000000 0006000000000000
pkt 24 FFFFFFFFFFFF0011 2233445508004500 001C000140000000
exp rej
pkt 24 FFFFFFFFFFFF0011 2233445508060001 0800060400010000
exp acc
fwd FFFFFFFFFFFF0011 2233445508060001 0800060400010000

//--- flist.f
+incdir+verilog
verilog/pf_pkg.sv
verilog/pkt_buffer.sv
verilog/inst_mem.sv
verilog/bpf_cpu.sv
verilog/packetfilter_core.sv
verification/pf_sva.sv
verification/pf_tb.sv
